//--- design/clic_params.svh
// sizes are global; NUM_IRQ must stay within the 0xB00 block and PRIO_WIDTH + 2 within 5 bits
`ifndef CLIC_PARAMS_SVH
`define CLIC_PARAMS_SVH

// number of interrupt entries
`define CLIC_NUM_IRQ 8

// priority bits per entry
// entry is pended + enable + prio, so 3 keeps it reachable by zimm
`define CLIC_PRIO_WIDTH 3

// machine status, only MIE is kept
`define CLIC_ADDR_MSTATUS 12'h300

// interrupt threshold, strictly-greater compare
`define CLIC_ADDR_MINTTHRESH 12'h347

// first entry CSR, entry k sits at base + k
`define CLIC_ADDR_ENTRY_BASE 12'hB00

// position of MIE inside mstatus
`define CLIC_MIE_BIT 3

`endif

//--- design/clic_pkg.sv
// shared CLIC types; widths come from clic_params.svh and entry_t must fit a 5-bit zimm
`include "clic_params.svh"

package clic_pkg;

  // 12-bit CSR address as in the RISC-V CSR space
  typedef logic [11:0] csr_addr_t;

  // data word for rs1, operand and read data
  typedef logic [31:0] word_t;

  // interrupt priority, larger value wins
  typedef logic [`CLIC_PRIO_WIDTH-1:0] prio_t;

  // entry index
  typedef logic [$clog2(`CLIC_NUM_IRQ)-1:0] irq_id_t;

  // CSR ops, encoded as funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    CSR_RW  = 3'b001,
    CSR_RS  = 3'b010,
    CSR_RC  = 3'b011,
    CSR_RWI = 3'b101,
    CSR_RSI = 3'b110,
    CSR_RCI = 3'b111
  } csr_op_t;

  // resolved update kind
  // none covers idle cycles and set/clear with a zero operand
  typedef enum logic [1:0] {
    KIND_NONE,
    KIND_WRITE,
    KIND_SET,
    KIND_CLEAR
  } csr_kind_t;

  // raw CSR command from the hart, valid is a one-cycle strobe
  typedef struct packed {
    logic      valid;
    csr_op_t   op;
    csr_addr_t addr;
    word_t     rs1_data;
    logic [4:0] zimm;
  } csr_req_t;

  // command after decode
  typedef struct packed {
    csr_kind_t kind;
    word_t     operand;
  } csr_cmd_t;

  // one interrupt entry
  // first member is the msb, so bit 0 = pended, bit 1 = enable, prio above
  typedef struct packed {
    prio_t prio;
    logic  enable;
    logic  pended;
  } entry_t;

  // request presented to the hart
  typedef struct packed {
    logic    valid;
    irq_id_t id;
    prio_t   prio;
  } irq_req_t;

endpackage

//--- design/clic_csr_decode.sv
// combinational CSR decode; unmapped addresses give no select, zero set/clear gives no write
`include "clic_params.svh"

module clic_csr_decode (
  input  clic_pkg::csr_req_t         csr_req,
  output clic_pkg::csr_cmd_t         cmd,
  output logic [`CLIC_NUM_IRQ-1:0]   entry_sel,
  output logic                       sel_mstatus,
  output logic                       sel_thresh,
  output logic                       any_sel
);

  clic_pkg::word_t operand;
  clic_pkg::csr_kind_t kind;

  // operand source
  // register ops take rs1, immediate ops take zimm zero-extended
  always_comb begin
    case (csr_req.op)
      clic_pkg::CSR_RWI,
      clic_pkg::CSR_RSI,
      clic_pkg::CSR_RCI: operand = {27'b0, csr_req.zimm};
      default:           operand = csr_req.rs1_data;
    endcase
  end

  // op to kind
  always_comb begin
    case (csr_req.op)
      clic_pkg::CSR_RW,
      clic_pkg::CSR_RWI: kind = clic_pkg::KIND_WRITE;
      clic_pkg::CSR_RS,
      clic_pkg::CSR_RSI: kind = clic_pkg::KIND_SET;
      clic_pkg::CSR_RC,
      clic_pkg::CSR_RCI: kind = clic_pkg::KIND_CLEAR;
      default:           kind = clic_pkg::KIND_NONE;
    endcase
    // idle cycle, nothing to do
    if (!csr_req.valid) begin
      kind = clic_pkg::KIND_NONE;
    end
    // set/clear with zero operand is a pure read
    if ((kind == clic_pkg::KIND_SET || kind == clic_pkg::KIND_CLEAR) && operand == '0) begin
      kind = clic_pkg::KIND_NONE;
    end
  end

  assign cmd.kind    = kind;
  assign cmd.operand = operand;

  // address decode
  // entries occupy base .. base + NUM_IRQ - 1
  always_comb begin
    for (int k = 0; k < `CLIC_NUM_IRQ; k++) begin
      entry_sel[k] = (csr_req.addr == clic_pkg::csr_addr_t'(`CLIC_ADDR_ENTRY_BASE + k));
    end
  end

  assign sel_mstatus = (csr_req.addr == `CLIC_ADDR_MSTATUS);
  assign sel_thresh  = (csr_req.addr == `CLIC_ADDR_MINTTHRESH);

  // false for unmapped addresses
  assign any_sel = (|entry_sel) | sel_mstatus | sel_thresh;

  // entry block must not overlap mstatus or mintthresh
  // otherwise two registers would drive read data and take the same write
  always_comb begin
    if (csr_req.valid) begin
      assert ($onehot0({entry_sel, sel_mstatus, sel_thresh}))
        else $error("csr decode: overlapping selects at addr %h", csr_req.addr);
    end
  end

endmodule

//--- design/clic_entry.sv
// one CLIC entry; update order is CSR, then take clear, then pend set, so a pend beats a take
`include "clic_params.svh"

module clic_entry (
  input  logic               clk,
  input  logic               rst_n,
  input  clic_pkg::csr_cmd_t cmd,
  input  logic               sel,
  input  logic               pend,
  input  logic               take,
  output clic_pkg::entry_t   entry
);

  localparam int entry_width = $bits(clic_pkg::entry_t);

  clic_pkg::entry_t csr_bits;
  clic_pkg::entry_t entry_nxt;

  // operand low bits in entry layout
  assign csr_bits = clic_pkg::entry_t'(cmd.operand[entry_width-1:0]);

  always_comb begin
    entry_nxt = entry;
    // software access first
    if (sel) begin
      case (cmd.kind)
        clic_pkg::KIND_WRITE: entry_nxt = csr_bits;
        clic_pkg::KIND_SET:   entry_nxt = clic_pkg::entry_t'(entry | csr_bits);
        clic_pkg::KIND_CLEAR: entry_nxt = clic_pkg::entry_t'(entry & ~csr_bits);
        default:              entry_nxt = entry;
      endcase
    end
    // hart took this entry
    if (take) begin
      entry_nxt.pended = 1'b0;
    end
    // source strobe last, never lost
    if (pend) begin
      entry_nxt.pended = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entry <= '0;
    end else begin
      entry <= entry_nxt;
    end
  end

  // a pend strobe always lands, whatever CSR write or take came with it
  a_pend_sets: assert property (
    @(posedge clk) disable iff (!rst_n)
    pend |=> entry.pended
  ) else $error("clic entry: pend strobe lost");

endmodule

//--- design/clic_global_csr.sv
// mstatus keeps only MIE, mintthresh keeps PRIO_WIDTH bits; read data is 0 without a select
`include "clic_params.svh"

module clic_global_csr (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  clic_pkg::csr_cmd_t                           cmd,
  input  logic                                         sel_mstatus,
  input  logic                                         sel_thresh,
  input  logic [`CLIC_NUM_IRQ-1:0]                     entry_sel,
  input  clic_pkg::entry_t [`CLIC_NUM_IRQ-1:0]         entries,
  output clic_pkg::prio_t                              thresh,
  output logic                                         mie,
  output clic_pkg::word_t                              rdata
);

  clic_pkg::prio_t op_prio;
  logic            op_mie;

  // operand bits that land in each register
  assign op_prio = cmd.operand[`CLIC_PRIO_WIDTH-1:0];
  assign op_mie  = cmd.operand[`CLIC_MIE_BIT];

  // mstatus.MIE
  // other mstatus bits read as zero and ignore writes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie <= 1'b0;
    end else if (sel_mstatus) begin
      case (cmd.kind)
        clic_pkg::KIND_WRITE: mie <= op_mie;
        clic_pkg::KIND_SET:   mie <= mie | op_mie;
        clic_pkg::KIND_CLEAR: mie <= mie & ~op_mie;
        default:              mie <= mie;
      endcase
    end
  end

  // mintthresh
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thresh <= '0;
    end else if (sel_thresh) begin
      case (cmd.kind)
        clic_pkg::KIND_WRITE: thresh <= op_prio;
        clic_pkg::KIND_SET:   thresh <= thresh | op_prio;
        clic_pkg::KIND_CLEAR: thresh <= thresh & ~op_prio;
        default:              thresh <= thresh;
      endcase
    end
  end

  // read mux, one-hot OR
  // shows the value before this cycle's write
  always_comb begin
    rdata = '0;
    if (sel_mstatus) begin
      rdata[`CLIC_MIE_BIT] = mie;
    end
    if (sel_thresh) begin
      rdata = rdata | clic_pkg::word_t'(thresh);
    end
    for (int k = 0; k < `CLIC_NUM_IRQ; k++) begin
      if (entry_sel[k]) begin
        rdata = rdata | clic_pkg::word_t'(entries[k]);
      end
    end
  end

endmodule

//--- design/clic_arbiter.sv
// irq is registered from last cycle's entry state; a take is ignored while irq.valid is low
`include "clic_params.svh"

module clic_arbiter (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  clic_pkg::entry_t [`CLIC_NUM_IRQ-1:0] entries,
  input  clic_pkg::prio_t                      thresh,
  input  logic                                 mie,
  input  logic                                 irq_take,
  output logic [`CLIC_NUM_IRQ-1:0]             take,
  output clic_pkg::irq_req_t                   irq
);

  logic [`CLIC_NUM_IRQ-1:0] eligible;
  logic                     best_valid;
  clic_pkg::irq_id_t        best_id;
  clic_pkg::prio_t          best_prio;

  // pended, enabled, strictly above threshold, global enable on
  always_comb begin
    for (int k = 0; k < `CLIC_NUM_IRQ; k++) begin
      eligible[k] = mie
                    && entries[k].pended
                    && entries[k].enable
                    && (entries[k].prio > thresh);
    end
  end

  // linear scan from index 0
  // strict compare keeps the lower index on equal prio
  always_comb begin
    best_valid = 1'b0;
    best_id    = '0;
    best_prio  = '0;
    for (int k = 0; k < `CLIC_NUM_IRQ; k++) begin
      if (eligible[k] && (!best_valid || entries[k].prio > best_prio)) begin
        best_valid = 1'b1;
        best_id    = clic_pkg::irq_id_t'(k);
        best_prio  = entries[k].prio;
      end
    end
  end

  // presented request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq <= '0;
    end else begin
      irq.valid <= best_valid;
      irq.id    <= best_id;
      irq.prio  <= best_prio;
    end
  end

  // steer the take strobe to the presented entry
  // no request, no take
  always_comb begin
    take = '0;
    if (irq_take && irq.valid) begin
      take[irq.id] = 1'b1;
    end
  end

  // winner was above the threshold with MIE set when it was registered
  a_irq_above_thresh: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq.valid |-> (irq.prio > $past(thresh)) && $past(mie)
  ) else $error("clic arbiter: irq prio %0d not above threshold", irq.prio);

endmodule

//--- design/n_clic.sv
// CLIC top; no vector table, trap CSRs, nesting or timestamps, all handshakes are strobes
`include "clic_params.svh"

module n_clic (
  input  logic                     clk,
  input  logic                     rst_n,
  input  clic_pkg::csr_req_t       csr_req,
  output clic_pkg::word_t          rdata,
  input  logic [`CLIC_NUM_IRQ-1:0] irq_pend,
  input  logic                     irq_take,
  output clic_pkg::irq_req_t       irq
);

  // decoded command and selects
  clic_pkg::csr_cmd_t       cmd;
  logic [`CLIC_NUM_IRQ-1:0] entry_sel;
  logic                     sel_mstatus;
  logic                     sel_thresh;

  // entry state and take steering
  clic_pkg::entry_t [`CLIC_NUM_IRQ-1:0] entries;
  logic [`CLIC_NUM_IRQ-1:0]             take;

  // global state
  clic_pkg::prio_t thresh;
  logic            mie;

  // read mux already gives zero without a select
  clic_csr_decode u_decode (
    .csr_req     (csr_req),
    .cmd         (cmd),
    .entry_sel   (entry_sel),
    .sel_mstatus (sel_mstatus),
    .sel_thresh  (sel_thresh),
    .any_sel     ()
  );

  // entry k answers at base + k
  for (genvar k = 0; k < `CLIC_NUM_IRQ; k++) begin : gen_entry
    clic_entry u_entry (
      .clk   (clk),
      .rst_n (rst_n),
      .cmd   (cmd),
      .sel   (entry_sel[k]),
      .pend  (irq_pend[k]),
      .take  (take[k]),
      .entry (entries[k])
    );
  end

  clic_global_csr u_global (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .sel_mstatus (sel_mstatus),
    .sel_thresh  (sel_thresh),
    .entry_sel   (entry_sel),
    .entries     (entries),
    .thresh      (thresh),
    .mie         (mie),
    .rdata       (rdata)
  );

  clic_arbiter u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .entries  (entries),
    .thresh   (thresh),
    .mie      (mie),
    .irq_take (irq_take),
    .take     (take),
    .irq      (irq)
  );

endmodule

//--- tests/tb_n_clic.sv
// checks run only while rst_n is high; the model mirrors entries, thresh and MIE cycle by cycle
`include "clic_params.svh"

module tb_n_clic;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_irq = `CLIC_NUM_IRQ;
  localparam int csr_pairs = 150;
  localparam int arb_cycles = 600;
  // reset, reset reads, csr pairs, directed, arbitration, drain
  localparam int planned_cycles = 8 + 16 + 2 * csr_pairs + 40 + arb_cycles + 4;
  localparam int timeout_cycles = 4 * planned_cycles;

  logic                clk = 1'b0;
  logic                rst_n;
  clic_pkg::csr_req_t  csr_req;
  clic_pkg::word_t     rdata;
  logic [num_irq-1:0]  irq_pend;
  logic                irq_take;
  clic_pkg::irq_req_t  irq;

  // model state and its next value
  clic_pkg::entry_t    m_entries [num_irq];
  clic_pkg::entry_t    nx_entries [num_irq];
  clic_pkg::prio_t     m_thresh;
  clic_pkg::prio_t     nx_thresh;
  logic                m_mie;
  logic                nx_mie;
  clic_pkg::irq_req_t  m_irq;
  clic_pkg::irq_req_t  m_best;
  clic_pkg::word_t     exp_rdata;

  logic [15:0] lfsr;
  int cycles = 0;
  int rdata_errors = 0;
  int irq_errors = 0;

  always #4 clk = ~clk;

  n_clic DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .csr_req  (csr_req),
    .rdata    (rdata),
    .irq_pend (irq_pend),
    .irq_take (irq_take),
    .irq      (irq)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic clic_pkg::csr_op_t random_op();
    logic [2:0] r;
    r = 3'(rand_bits(3));
    case (r)
      3'd0:    return clic_pkg::CSR_RW;
      3'd1:    return clic_pkg::CSR_RS;
      3'd2:    return clic_pkg::CSR_RC;
      3'd3:    return clic_pkg::CSR_RSI;
      3'd4:    return clic_pkg::CSR_RCI;
      default: return clic_pkg::CSR_RWI;
    endcase
  endfunction

  function automatic clic_pkg::csr_addr_t entry_addr(input int k);
    return clic_pkg::csr_addr_t'(`CLIC_ADDR_ENTRY_BASE + k);
  endfunction

  // mapped registers, entries, and holes around the entry block
  function automatic clic_pkg::csr_addr_t random_addr();
    logic [2:0] r;
    r = 3'(rand_bits(3));
    case (r)
      3'd0:    return `CLIC_ADDR_MSTATUS;
      3'd1:    return `CLIC_ADDR_MINTTHRESH;
      3'd6:    return entry_addr(num_irq + int'(rand_bits(3)));
      3'd7:    return 12'(rand_bits(12));
      default: return entry_addr(int'(rand_bits($clog2(num_irq))));
    endcase
  endfunction

  // zero a quarter of the time, to reach the no-write case
  function automatic clic_pkg::word_t random_word();
    if (rand_bits(2) == 32'd0) begin
      return '0;
    end
    return rand_bits(32);
  endfunction

  function automatic logic [4:0] random_zimm();
    if (rand_bits(2) == 32'd0) begin
      return 5'd0;
    end
    return 5'(rand_bits(5));
  endfunction

  function automatic clic_pkg::csr_req_t make_req(input logic valid, input clic_pkg::csr_op_t op,
      input clic_pkg::csr_addr_t addr, input clic_pkg::word_t rs1, input logic [4:0] zimm);
    clic_pkg::csr_req_t r;
    r.valid = valid;
    r.op = op;
    r.addr = addr;
    r.rs1_data = rs1;
    r.zimm = zimm;
    return r;
  endfunction

  // RISC-V CSR semantics on a full word
  function automatic clic_pkg::word_t apply_op(input clic_pkg::csr_op_t op,
      input clic_pkg::word_t old, input clic_pkg::word_t opnd);
    case (op)
      clic_pkg::CSR_RW, clic_pkg::CSR_RWI: return opnd;
      clic_pkg::CSR_RS, clic_pkg::CSR_RSI: return old | opnd;
      default:                             return old & ~opnd;
    endcase
  endfunction

  function automatic clic_pkg::word_t operand_of(input clic_pkg::csr_req_t r);
    if (r.op inside {clic_pkg::CSR_RWI, clic_pkg::CSR_RSI, clic_pkg::CSR_RCI}) begin
      return {27'b0, r.zimm};
    end
    return r.rs1_data;
  endfunction

  task automatic drive_cycle(input clic_pkg::csr_req_t r, input logic [num_irq-1:0] pend,
      input logic take);
    @(negedge clk);
    csr_req = r;
    irq_pend = pend;
    irq_take = take;
  endtask

  task automatic csr_cycle(input clic_pkg::csr_op_t op, input clic_pkg::csr_addr_t addr,
      input clic_pkg::word_t rs1, input logic [4:0] zimm);
    drive_cycle(make_req(1'b1, op, addr, rs1, zimm), '0, 1'b0);
  endtask

  // set with zero operand reads without writing
  task automatic read_csr(input clic_pkg::csr_addr_t addr);
    csr_cycle(clic_pkg::CSR_RS, addr, '0, 5'd0);
  endtask

  task automatic pend_cycle(input logic [num_irq-1:0] pend, input logic take);
    drive_cycle(make_req(1'b0, clic_pkg::CSR_RS, '0, '0, 5'd0), pend, take);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) pend_cycle('0, 1'b0);
  endtask

  // next model state
  // csr update first, then take clear, then pend set
  always_comb begin
    clic_pkg::word_t opnd;
    clic_pkg::word_t upd;
    opnd = operand_of(csr_req);
    upd = '0;
    nx_thresh = m_thresh;
    nx_mie = m_mie;
    for (int k = 0; k < num_irq; k++) begin
      nx_entries[k] = m_entries[k];
    end
    if (csr_req.valid) begin
      if (csr_req.addr == `CLIC_ADDR_MSTATUS) begin
        upd = apply_op(csr_req.op, clic_pkg::word_t'(m_mie) << `CLIC_MIE_BIT, opnd);
        nx_mie = upd[`CLIC_MIE_BIT];
      end
      if (csr_req.addr == `CLIC_ADDR_MINTTHRESH) begin
        upd = apply_op(csr_req.op, clic_pkg::word_t'(m_thresh), opnd);
        nx_thresh = upd[`CLIC_PRIO_WIDTH-1:0];
      end
      for (int k = 0; k < num_irq; k++) begin
        if (csr_req.addr == entry_addr(k)) begin
          upd = apply_op(csr_req.op, clic_pkg::word_t'(m_entries[k]), opnd);
          nx_entries[k] = clic_pkg::entry_t'(upd[$bits(clic_pkg::entry_t)-1:0]);
        end
      end
    end
    for (int k = 0; k < num_irq; k++) begin
      // take hits only the presented entry
      if (irq_take && m_irq.valid && m_irq.id == clic_pkg::irq_id_t'(k)) begin
        nx_entries[k].pended = 1'b0;
      end
      if (irq_pend[k]) begin
        nx_entries[k].pended = 1'b1;
      end
    end
  end

  // winner, scanned from the top index down
  // >= lets a lower index take over an equal prio
  always_comb begin
    m_best = '0;
    for (int k = num_irq - 1; k >= 0; k--) begin
      if (m_mie && m_entries[k].pended && m_entries[k].enable
          && m_entries[k].prio > m_thresh
          && (!m_best.valid || m_entries[k].prio >= m_best.prio)) begin
        m_best.valid = 1'b1;
        m_best.id = clic_pkg::irq_id_t'(k);
        m_best.prio = m_entries[k].prio;
      end
    end
  end

  // expected read, value before the write, zero when unmapped
  always_comb begin
    exp_rdata = '0;
    if (csr_req.addr == `CLIC_ADDR_MSTATUS) begin
      exp_rdata = clic_pkg::word_t'(m_mie) << `CLIC_MIE_BIT;
    end
    if (csr_req.addr == `CLIC_ADDR_MINTTHRESH) begin
      exp_rdata = clic_pkg::word_t'(m_thresh);
    end
    for (int k = 0; k < num_irq; k++) begin
      if (csr_req.addr == entry_addr(k)) begin
        exp_rdata = clic_pkg::word_t'(m_entries[k]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < num_irq; k++) begin
        m_entries[k] <= '0;
      end
      m_thresh <= '0;
      m_mie <= 1'b0;
      m_irq <= '0;
    end else begin
      for (int k = 0; k < num_irq; k++) begin
        m_entries[k] <= nx_entries[k];
      end
      m_thresh <= nx_thresh;
      m_mie <= nx_mie;
      m_irq <= m_best;
    end
  end

  rdata_matches: assert property (
    @(posedge clk) disable iff (!rst_n)
    rdata == exp_rdata
  ) else begin
    rdata_errors++;
    $display("error at %0t: rdata %h at addr %h, expected %h", $time,
             $sampled(rdata), $sampled(csr_req.addr), $sampled(exp_rdata));
  end

  // id and prio only matter while valid
  irq_matches: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq.valid == m_irq.valid
    && (!irq.valid || (irq.id == m_irq.id && irq.prio == m_irq.prio))
  ) else begin
    irq_errors++;
    $display("error at %0t: irq %0b/%0d/%0d, expected %0b/%0d/%0d", $time,
             $sampled(irq.valid), $sampled(irq.id), $sampled(irq.prio),
             $sampled(m_irq.valid), $sampled(m_irq.id), $sampled(m_irq.prio));
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: stimulus did not finish within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    clic_pkg::csr_addr_t addr;
    clic_pkg::csr_req_t  req;
    logic [num_irq-1:0]  pend;
    logic [1:0]          kind_sel;
    logic                take;
    lfsr = 16'd37626;
    rst_n = 1'b0;
    csr_req = make_req(1'b0, clic_pkg::CSR_RS, '0, '0, 5'd0);
    irq_pend = '0;
    irq_take = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // everything reads zero after reset
    read_csr(`CLIC_ADDR_MSTATUS);
    read_csr(`CLIC_ADDR_MINTTHRESH);
    for (int k = 0; k < num_irq; k++) begin
      read_csr(entry_addr(k));
    end
    read_csr(entry_addr(num_irq));
    idle_cycles(2);

    // random ops, each followed by a read back
    for (int i = 0; i < csr_pairs; i++) begin
      addr = random_addr();
      csr_cycle(random_op(), addr, random_word(), random_zimm());
      read_csr(addr);
    end

    // wipe entries left over from the random phase
    for (int k = 0; k < num_irq; k++) begin
      csr_cycle(clic_pkg::CSR_RWI, entry_addr(k), '0, 5'd0);
    end
    // single eligible entry: MIE on, thresh 2, entry 3 enabled at prio 5
    csr_cycle(clic_pkg::CSR_RSI, `CLIC_ADDR_MSTATUS, '0, 5'd8);
    csr_cycle(clic_pkg::CSR_RWI, `CLIC_ADDR_MINTTHRESH, '0, 5'd2);
    csr_cycle(clic_pkg::CSR_RWI, entry_addr(3), '0, 5'd22);
    pend_cycle(num_irq'(1 << 3), 1'b0);
    idle_cycles(3);
    pend_cycle('0, 1'b1);
    idle_cycles(2);
    // prio equal to thresh stays quiet
    csr_cycle(clic_pkg::CSR_RWI, entry_addr(4), '0, 5'd10);
    pend_cycle(num_irq'(1 << 4), 1'b0);
    idle_cycles(3);
    // MIE off masks entry 3, turning it back on releases it
    csr_cycle(clic_pkg::CSR_RCI, `CLIC_ADDR_MSTATUS, '0, 5'd8);
    pend_cycle(num_irq'(1 << 3), 1'b0);
    idle_cycles(3);
    csr_cycle(clic_pkg::CSR_RSI, `CLIC_ADDR_MSTATUS, '0, 5'd8);
    idle_cycles(3);
    // take and pend together keep it pended
    pend_cycle(num_irq'(1 << 3), 1'b1);
    idle_cycles(2);
    read_csr(entry_addr(3));
    idle_cycles(2);

    // random arbitration traffic
    csr_cycle(clic_pkg::CSR_RWI, `CLIC_ADDR_MINTTHRESH, '0, 5'd1);
    for (int i = 0; i < arb_cycles; i++) begin
      kind_sel = 2'(rand_bits(2));
      req = make_req(1'b0, clic_pkg::CSR_RS, '0, '0, 5'd0);
      if (kind_sel == 2'd0) begin
        addr = entry_addr(int'(rand_bits($clog2(num_irq))));
        req = make_req(1'b1, random_op(), addr, random_word(), random_zimm());
      end else if (kind_sel == 2'd1 && rand_bits(3) == 32'd0) begin
        req = make_req(1'b1, random_op(), `CLIC_ADDR_MINTTHRESH, random_word(), random_zimm());
      end
      pend = num_irq'(rand_bits(num_irq) & rand_bits(num_irq));
      take = (rand_bits(2) == 32'd0);
      drive_cycle(req, pend, take);
    end
    idle_cycles(4);

    $display("checks done: %0d rdata errors, %0d irq errors", rdata_errors, irq_errors);
    if (rdata_errors + irq_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- n_clic.f
+incdir+design
design/clic_pkg.sv
design/clic_csr_decode.sv
design/clic_entry.sv
design/clic_global_csr.sv
design/clic_arbiter.sv
design/n_clic.sv
tests/tb_n_clic.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f n_clic.f \
  --top-module tb_n_clic \
  -o sim_tb

./obj_dir/sim_tb | tee log.txt

if grep -q "Simulation completed successfully" log.txt; then
  echo "run passed"
else
  echo "run failed"
  exit 1
fi
